// ==== src/rp_params.svh ====
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// data path widths
//////////////////////////////////////////////////////////////////////

`define RP_DW       14  // ADC and DAC sample width
`define RP_ADC_W    16  // ADC pin bus, lowest two bits reserved
`define RP_NCH      2   // channel count

//////////////////////////////////////////////////////////////////////
// system bus
//////////////////////////////////////////////////////////////////////

`define RP_BUS_AW      32
`define RP_BUS_DW      32
`define RP_REGION_LSB  20  // region select bits
`define RP_REGION_MSB  22
`define RP_NREGION     8

// housekeeping region offsets
`define RP_OFS_ID    20'h00000  // read only
`define RP_OFS_LOOP  20'h0000C  // digital loop flag
`define RP_OFS_LED   20'h00030

// channel region offsets
`define RP_OFS_CH_A  20'h00000
`define RP_OFS_CH_B  20'h00004

`define RP_ID_VALUE  32'h7270_0001

`endif

// ==== src/rp_pkg.sv ====
package rp_pkg;

  // address region, taken from bits 22..20
  // values 2..7 have no name and stay unused
  typedef enum logic [2:0] {
    REGION_HK  = 3'd0,  // housekeeping
    REGION_DSP = 3'd1   // channel offsets
  } bus_region_e;

  // access in flight on the system bus
  typedef enum logic [1:0] {
    BUS_IDLE  = 2'd0,
    BUS_WRITE = 2'd1,
    BUS_READ  = 2'd2
  } bus_op_e;

  // what a channel adds its offset to
  typedef enum logic {
    SRC_ADC  = 1'b0,  // fresh ADC sample
    SRC_LOOP = 1'b1   // own last result
  } chan_src_e;

endpackage

// ==== src/adc_capture.sv ====
`timescale 1ns/1ns
`include "rp_params.svh"

module adc_capture (
  input  logic                                  adc_clk,
  input  logic                                  rst_i,
  input  logic        [`RP_ADC_W-1:0]           adc_dat_a_i,
  input  logic        [`RP_ADC_W-1:0]           adc_dat_b_i,
  output logic signed [`RP_NCH-1:0][`RP_DW-1:0] adc_sample_o
);

  localparam int ADC_LSB = `RP_ADC_W - `RP_DW;  // reserved low pins

  // mid-scale code, decodes to zero
  localparam logic [`RP_DW-1:0] MID_CODE = {1'b0, {(`RP_DW-1){1'b1}}};

  logic [`RP_NCH-1:0][`RP_DW-1:0] adc_raw;  // pin registers, offset binary

  // these should land in the IO block registers
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      adc_raw <= {`RP_NCH{MID_CODE}};
    end
    else
    begin
      adc_raw[0] <= adc_dat_a_i[`RP_ADC_W-1:ADC_LSB];
      adc_raw[1] <= adc_dat_b_i[`RP_ADC_W-1:ADC_LSB];
    end
  end

  // negative slope offset binary to two's complement
  always_comb
  begin
    for (int k = 0; k < `RP_NCH; k++)
    begin
      adc_sample_o[k] = {adc_raw[k][`RP_DW-1], ~adc_raw[k][`RP_DW-2:0]};  // keep msb
    end
  end

endmodule

// ==== src/analog_channel.sv ====
`timescale 1ns/1ns
`include "rp_params.svh"

module analog_channel (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  logic signed [`RP_DW-1:0] adc_sample_i,  // two's complement sample
  input  rp_pkg::chan_src_e        src_i,         // ADC or loopback
  input  logic signed [`RP_DW-1:0] offset_i,
  output logic signed [`RP_DW-1:0] chan_out_o
);

  import rp_pkg::*;

  // clamp limits of the output word
  localparam logic signed [`RP_DW-1:0] SAT_MAX = {1'b0, {(`RP_DW-1){1'b1}}};
  localparam logic signed [`RP_DW-1:0] SAT_MIN = {1'b1, {(`RP_DW-1){1'b0}}};

  logic signed [`RP_DW-1:0] operand;  // selected input
  logic signed [`RP_DW:0]   sum;      // one guard bit
  logic signed [`RP_DW-1:0] sat;      // clamped sum

  //////////////////////////////////////////////////////////////////////
  // source select
  //////////////////////////////////////////////////////////////////////

  // loop mode feeds back the last result
  always_comb
  begin
    if (src_i == SRC_LOOP)
    begin
      operand = chan_out_o;
    end
    else
    begin
      operand = adc_sample_i;
    end
  end

  // sign extend both terms by one bit
  assign sum = {operand[`RP_DW-1], operand} + {offset_i[`RP_DW-1], offset_i};

  // the top two bits disagree on overflow
  always_comb
  begin
    case (sum[`RP_DW:`RP_DW-1])
      2'b01:   sat = SAT_MAX;             // positive overflow
      2'b10:   sat = SAT_MIN;             // negative overflow
      default: sat = sum[`RP_DW-1:0];     // in range
    endcase
  end

  // output register
  // acts as a saturating accumulator in loop mode
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      chan_out_o <= '0;
    end
    else
    begin
      chan_out_o <= sat;
    end
  end

endmodule

// ==== src/dac_interleave.sv ====
`timescale 1ns/1ns
`include "rp_params.svh"

module dac_interleave (
  input  logic                                  adc_clk,
  input  logic                                  rst_i,
  input  logic signed [`RP_NCH-1:0][`RP_DW-1:0] chan_i,     // channel results
  output logic        [`RP_DW-1:0]              dac_dat_o,  // DAC code
  output logic                                  dac_sel_o,  // high carries channel A
  output logic                                  dac_rst_o
);

  logic                     next_a;     // next cycle carries A
  logic                     ch_idx;     // channel picked for next cycle
  logic signed [`RP_DW-1:0] chan_word;
  logic        [`RP_DW-1:0] dac_code;

  // toggle state is the select line itself
  assign next_a = ~dac_sel_o;
  assign ch_idx = next_a ? 1'b0 : 1'b1;  // A is index 0

  assign chan_word = chan_i[ch_idx];

  // back to negative slope offset binary
  assign dac_code = {chan_word[`RP_DW-1], ~chan_word[`RP_DW-2:0]};

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  // each channel gets every second cycle
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end
    else
    begin
      dac_sel_o <= next_a;
      dac_dat_o <= dac_code;
    end
  end

  // DAC reset, held one cycle past rst_i
  always_ff @(posedge adc_clk)
  begin
    dac_rst_o <= rst_i;
  end

endmodule

// ==== src/sys_bus_regs.sv ====
`timescale 1ns/1ns
`include "rp_params.svh"

module sys_bus_regs (
  input  logic                                  adc_clk,
  input  logic                                  rst_i,
  // system bus
  input  logic        [`RP_BUS_AW-1:0]          sys_addr_i,
  input  logic        [`RP_BUS_DW-1:0]          sys_wdata_i,
  input  logic                                  sys_wen_i,    // write strobe
  input  logic                                  sys_ren_i,    // read strobe
  output logic        [`RP_BUS_DW-1:0]          sys_rdata_o,
  output logic                                  sys_ack_o,
  // register outputs
  output logic        [7:0]                     led_o,
  output rp_pkg::chan_src_e                     src_o,        // digital loop flag
  output logic signed [`RP_NCH-1:0][`RP_DW-1:0] offset_o
);

  import rp_pkg::*;

  localparam int OFS_W = `RP_REGION_LSB;  // offset bits below the region

  bus_region_e            region;
  logic [`RP_NREGION-1:0] region_cs;  // one hot region select
  logic                   hk_cs;
  logic                   dsp_cs;
  logic [OFS_W-1:0]       ofs;        // offset within region
  bus_op_e                op;         // access starting this cycle
  bus_op_e                op_q;       // access being acknowledged
  logic [`RP_BUS_DW-1:0]  rdata;
  logic [`RP_BUS_DW-1:0]  rdata_q;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  assign region    = bus_region_e'(sys_addr_i[`RP_REGION_MSB:`RP_REGION_LSB]);
  assign region_cs = `RP_NREGION'(1) << region;
  assign hk_cs     = region_cs[REGION_HK];
  assign dsp_cs    = region_cs[REGION_DSP];  // other regions ack and read zero
  assign ofs       = sys_addr_i[OFS_W-1:0];

  // write wins if both strobes come together
  always_comb
  begin
    if (sys_wen_i)
    begin
      op = BUS_WRITE;
    end
    else if (sys_ren_i)
    begin
      op = BUS_READ;
    end
    else
    begin
      op = BUS_IDLE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////

  // write lands on the edge that raises ack
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      led_o    <= '0;
      src_o    <= SRC_ADC;
      offset_o <= '0;
    end
    else if (op == BUS_WRITE)
    begin
      if (hk_cs)
      begin
        case (ofs)
          `RP_OFS_LED:  led_o <= sys_wdata_i[7:0];
          `RP_OFS_LOOP: src_o <= sys_wdata_i[0] ? SRC_LOOP : SRC_ADC;
          default:      ;  // ID is read only
        endcase
      end
      if (dsp_cs)
      begin
        case (ofs)
          `RP_OFS_CH_A: offset_o[0] <= sys_wdata_i[`RP_DW-1:0];
          `RP_OFS_CH_B: offset_o[1] <= sys_wdata_i[`RP_DW-1:0];
          default:      ;
        endcase
      end
    end
  end

  // read mux, zero for anything unmapped
  always_comb
  begin
    rdata = '0;
    if (hk_cs)
    begin
      case (ofs)
        `RP_OFS_ID:   rdata = `RP_ID_VALUE;
        `RP_OFS_LOOP: rdata = {{(`RP_BUS_DW-1){1'b0}}, src_o == SRC_LOOP};
        `RP_OFS_LED:  rdata = {{(`RP_BUS_DW-8){1'b0}}, led_o};
        default:      rdata = '0;
      endcase
    end
    if (dsp_cs)
    begin
      case (ofs)
        `RP_OFS_CH_A: rdata = {{(`RP_BUS_DW-`RP_DW){offset_o[0][`RP_DW-1]}}, offset_o[0]};
        `RP_OFS_CH_B: rdata = {{(`RP_BUS_DW-`RP_DW){offset_o[1][`RP_DW-1]}}, offset_o[1]};
        default:      rdata = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // acknowledge
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      op_q <= BUS_IDLE;
    end
    else
    begin
      op_q <= op;  // one cycle after the strobe
    end
  end

  // read data captured with the strobe
  always_ff @(posedge adc_clk)
  begin
    if (op == BUS_READ)
    begin
      rdata_q <= rdata;
    end
  end

  assign sys_ack_o   = (op_q != BUS_IDLE);
  assign sys_rdata_o = (op_q == BUS_READ) ? rdata_q : '0;  // zero outside reads

endmodule

// ==== src/rp_top.sv ====
`timescale 1ns/1ns
`include "rp_params.svh"

module rp_top (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  // ADC pins
  input  logic [`RP_ADC_W-1:0]  adc_dat_a_i,  // channel A
  input  logic [`RP_ADC_W-1:0]  adc_dat_b_i,  // channel B
  // DAC pins
  output logic [`RP_DW-1:0]     dac_dat_o,    // interleaved data
  output logic                  dac_sel_o,    // high for channel A
  output logic                  dac_rst_o,
  output logic [7:0]            led_o,
  // system bus
  input  logic [`RP_BUS_AW-1:0] sys_addr_i,
  input  logic [`RP_BUS_DW-1:0] sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [`RP_BUS_DW-1:0] sys_rdata_o,
  output logic                  sys_ack_o
);

  import rp_pkg::*;

  logic signed [`RP_NCH-1:0][`RP_DW-1:0] adc_sample;   // two's complement samples
  logic signed [`RP_NCH-1:0][`RP_DW-1:0] chan_out;     // channel results
  logic signed [`RP_NCH-1:0][`RP_DW-1:0] chan_offset;  // from bus registers
  chan_src_e                             chan_src;     // shared loop select

  //////////////////////////////////////////////////////////////////////
  // ADC input
  //////////////////////////////////////////////////////////////////////

  adc_capture u_adc (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .adc_dat_a_i  (adc_dat_a_i),
    .adc_dat_b_i  (adc_dat_b_i),
    .adc_sample_o (adc_sample)
  );

  // one processing stage per channel
  for (genvar k = 0; k < `RP_NCH; k++)
  begin : g_chan
    analog_channel u_chan (
      .adc_clk      (adc_clk),
      .rst_i        (rst_i),
      .adc_sample_i (adc_sample[k]),
      .src_i        (chan_src),
      .offset_i     (chan_offset[k]),
      .chan_out_o   (chan_out[k])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // DAC output
  //////////////////////////////////////////////////////////////////////

  dac_interleave u_dac (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .chan_i    (chan_out),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

  // slow control
  sys_bus_regs u_regs (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .led_o       (led_o),
    .src_o       (chan_src),
    .offset_o    (chan_offset)
  );

endmodule

// ==== verification/rp_asserts.sv ====
`timescale 1ns/1ns
`include "rp_params.svh"

module rp_asserts (
  input logic                  adc_clk,
  input logic                  rst_i,
  input logic                  sys_wen_i,
  input logic                  sys_ren_i,
  input logic                  sys_ack_o,
  input logic [`RP_BUS_DW-1:0] sys_rdata_o,
  input logic                  dac_sel_o,
  input logic                  dac_rst_o
);

  int unsigned fail_cnt = 0;  // polled by tb_top each cycle

  task automatic flag_failure(string what);
    fail_cnt++;
    $error("%s", what);
  endtask

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  // ack exactly one cycle after each strobe
  a_ack_follows: assert property (@(posedge adc_clk) disable iff (rst_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o) else flag_failure("no ack after strobe");

  a_ack_needs_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i)) else flag_failure("ack without strobe");

  // read data only while a read is acknowledged
  a_rdata_idle: assert property (@(posedge adc_clk) disable iff (rst_i)
    (!sys_ack_o || $past(sys_wen_i)) |-> (sys_rdata_o == '0))
    else flag_failure("read data outside a read ack");

  //////////////////////////////////////////////////////////////////////
  // DAC side
  //////////////////////////////////////////////////////////////////////

  // A and B alternate
  a_sel_toggles: assert property (@(posedge adc_clk) disable iff (rst_i)
    1'b1 |=> (dac_sel_o != $past(dac_sel_o))) else flag_failure("dac_sel_o stuck");

  a_dac_rst_on: assert property (@(posedge adc_clk)
    rst_i |=> dac_rst_o) else flag_failure("dac_rst_o low during reset");

  a_dac_rst_off: assert property (@(posedge adc_clk)
    !rst_i |=> !dac_rst_o) else flag_failure("dac_rst_o high after release");

endmodule

bind rp_top rp_asserts u_asserts (
  .adc_clk     (adc_clk),
  .rst_i       (rst_i),
  .sys_wen_i   (sys_wen_i),
  .sys_ren_i   (sys_ren_i),
  .sys_ack_o   (sys_ack_o),
  .sys_rdata_o (sys_rdata_o),
  .dac_sel_o   (dac_sel_o),
  .dac_rst_o   (dac_rst_o)
);

// ==== verification/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  logic clk = 1'b0;  // starts low, first rise at half period

  assign clk_o = clk;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== verification/tb_top.sv ====
`timescale 1ns/1ns
`include "rp_params.svh"

module tb_top;

  localparam int CLK_NS   = 40;
  localparam int RST_CYC  = 10;
  localparam int RUN_CYC  = 30;  // per data path run
  localparam int N_RUN    = 6;
  localparam int N_BUS    = 25;  // accesses of two cycles each
  localparam int TEST_CYC = RST_CYC + N_RUN * RUN_CYC + 2 * N_BUS + 4;

  // region in bits 22..20
  localparam logic [31:0] A_ID   = 32'h0000_0000;
  localparam logic [31:0] A_LOOP = 32'h0000_000C;
  localparam logic [31:0] A_LED  = 32'h0000_0030;
  localparam logic [31:0] A_CH_A = 32'h0010_0000;
  localparam logic [31:0] A_CH_B = 32'h0010_0004;

  logic                 adc_clk;
  logic                 rst_i;
  logic [`RP_ADC_W-1:0] adc_dat_a_i;
  logic [`RP_ADC_W-1:0] adc_dat_b_i;
  logic [`RP_DW-1:0]    dac_dat_o;
  logic                 dac_sel_o;
  logic                 dac_rst_o;
  logic [7:0]           led_o;
  logic [31:0]          sys_addr_i;
  logic [31:0]          sys_wdata_i;
  logic                 sys_wen_i;
  logic                 sys_ren_i;
  logic [31:0]          sys_rdata_o;
  logic                 sys_ack_o;
  int                   seed = 5;

  //////////////////////////////////////////////////////////////////////
  // reference model state
  //////////////////////////////////////////////////////////////////////

  int                m_smp [2];   // registered samples, decoded
  int                m_chan [2];  // channel results
  int                m_ofs [2];
  logic              m_loop;
  logic [7:0]        m_led;
  logic              m_sel;
  logic [`RP_DW-1:0] m_dat;
  logic              m_dac_rst;
  logic              m_ack;

  clk_gen #(.PERIOD_NS(CLK_NS)) u_clk (.clk_o(adc_clk));

  rp_top dut (.*);

  function automatic int sext(logic [`RP_DW-1:0] w);
    return w[`RP_DW-1] ? int'(w) - (1 << `RP_DW) : int'(w);
  endfunction

  function automatic int clamp(int v);
    return (v > 8191) ? 8191 : ((v < -8192) ? -8192 : v);
  endfunction

  // stage order reversed so each reads last cycle's values
  always @(posedge adc_clk)
  begin
    m_dac_rst = rst_i;
    if (rst_i)
    begin
      m_sel  = 1'b0;
      m_dat  = '0;
      m_ack  = 1'b0;
      m_loop = 1'b0;
      m_led  = '0;
      m_smp  = '{0, 0};  // mid-scale code decodes to zero
      m_chan = '{0, 0};
      m_ofs  = '{0, 0};
    end
    else
    begin
      m_sel = ~m_sel;
      m_dat = 14'(m_sel ? m_chan[0] : m_chan[1]) ^ 14'h1FFF;  // sign kept and rest flipped
      for (int k = 0; k < 2; k++)
      begin
        m_chan[k] = clamp((m_loop ? m_chan[k] : m_smp[k]) + m_ofs[k]);
      end
      m_smp[0] = sext(adc_dat_a_i[15:2] ^ 14'h1FFF);  // negative slope code
      m_smp[1] = sext(adc_dat_b_i[15:2] ^ 14'h1FFF);
      m_ack    = sys_wen_i | sys_ren_i;
      if (sys_wen_i)
      begin
        case (sys_addr_i)
          A_LOOP:  m_loop   = sys_wdata_i[0];
          A_LED:   m_led    = sys_wdata_i[7:0];
          A_CH_A:  m_ofs[0] = sext(sys_wdata_i[13:0]);
          A_CH_B:  m_ofs[1] = sext(sys_wdata_i[13:0]);
          default: ;
        endcase
      end
    end
  end

  // outputs settled since the rising edge
  always @(negedge adc_clk)
  begin
    assert (dac_rst_o == m_dac_rst)
      else report_mismatch("dac_rst_o", 32'(dac_rst_o), 32'(m_dac_rst));
    assert (dac_sel_o == m_sel)
      else report_mismatch("dac_sel_o", 32'(dac_sel_o), 32'(m_sel));
    assert (dac_dat_o == m_dat)
      else report_mismatch("dac_dat_o", 32'(dac_dat_o), 32'(m_dat));
    assert (sys_ack_o == m_ack)
      else report_mismatch("sys_ack_o", 32'(sys_ack_o), 32'(m_ack));
    assert (led_o == m_led)
      else report_mismatch("led_o", 32'(led_o), 32'(m_led));
    assert (dut.u_asserts.fail_cnt == 0)
      else abort_run("a bound assertion on rp_top failed");
    adc_dat_a_i = 16'($random(seed));  // fresh ADC data every cycle
    adc_dat_b_i = 16'($random(seed));
  end

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge adc_clk);
  endtask

  // strobe cycle then the ack cycle
  task automatic bus_write(logic [31:0] addr, logic [31:0] data);
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    @(negedge adc_clk);
    sys_wen_i = 1'b0;
    @(negedge adc_clk);
  endtask

  task automatic bus_read(logic [31:0] addr, logic [31:0] exp);
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    @(negedge adc_clk);
    sys_ren_i = 1'b0;
    assert (sys_rdata_o == exp)
      else report_mismatch("sys_rdata_o", sys_rdata_o, exp);
    @(negedge adc_clk);
  endtask

  initial
  begin
    #(4 * TEST_CYC * CLK_NS);
    abort_run("watchdog expired before the test sequence ended");
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_i       = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    idle(RST_CYC);
    rst_i = 1'b0;
    idle(RUN_CYC);  // pass-through with zero offsets
    bus_read(A_ID, `RP_ID_VALUE);
    bus_write(A_LED, 32'h0000_00A5);
    bus_read(A_LED, 32'h0000_00A5);
    // offsets at the clamp limits
    bus_write(A_CH_A, 32'h0000_1FFF);
    bus_write(A_CH_B, 32'h0000_2000);
    bus_read(A_CH_B, 32'hFFFF_E000);
    idle(RUN_CYC);
    bus_write(A_CH_A, 32'h0000_2000);
    bus_write(A_CH_B, 32'h0000_1FFF);
    bus_read(A_CH_A, 32'hFFFF_E000);
    idle(RUN_CYC);
    bus_write(A_CH_A, 32'h0000_0123);
    bus_write(A_CH_B, 32'h0000_3F00);  // -256
    bus_read(A_CH_B, 32'hFFFF_FF00);
    idle(RUN_CYC);
    // unused regions and unmapped offsets
    bus_write(32'h0030_0000, 32'hFFFF_FFFF);
    bus_read(32'h0030_0000, '0);
    bus_read(32'h0070_0010, '0);
    bus_read(32'h0000_0008, '0);
    bus_read(32'h0010_0008, '0);
    // digital loop ramps up into the top limit
    bus_write(A_CH_A, 32'h0000_0FFF);
    bus_write(A_CH_B, 32'h0000_0555);
    bus_write(A_LOOP, 32'h0000_0001);
    bus_read(A_LOOP, 32'h0000_0001);
    idle(RUN_CYC);
    bus_write(A_CH_A, 32'h0000_3000);  // -4096
    bus_write(A_CH_B, 32'h0000_3AAB);  // -1365
    idle(RUN_CYC);
    bus_write(A_LOOP, '0);
    bus_write(A_LED, '0);
    idle(4);
    #(CLK_NS / 4);  // past the checks of the last falling edge
    if (dut.u_asserts.fail_cnt == 0)
    begin
      $display("TEST OK");
      $finish;
    end
    else
    begin
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== compile.f ====
+incdir+src
src/rp_pkg.sv
src/adc_capture.sv
src/analog_channel.sv
src/dac_interleave.sv
src/sys_bus_regs.sv
src/rp_top.sv
verification/rp_asserts.sv
verification/clk_gen.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_top -f compile.f \
  && ./obj_dir/Vtb_top +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
